// File: common/vid_pkg.sv
/* shared types and register numbers for the video controller
   VRAM_DEPTH must be a power of two, the VRAM index is the low address bits */
`default_nettype none

package vid_pkg;

typedef logic [15:0] word_t;        // one vram word
typedef logic [15:0] addr_t;        // vram word address
typedef logic [11:0] rgb_t;         // {red, green, blue}, 4 bits each
typedef logic [3:0]  intr_t;        // bit 0 vblank, bits 1-3 software

localparam int VRAM_DEPTH = 4096;   // words of video ram

// cpu register numbers
localparam logic [3:0] REG_VRAM_ADDR = 4'h0;
localparam logic [3:0] REG_VRAM_DATA = 4'h1;
localparam logic [3:0] REG_INT_CTRL  = 4'h2;
localparam logic [3:0] REG_STATUS    = 4'h3;
localparam logic [3:0] REG_SOFT_INTR = 4'h4;

endpackage

`default_nettype wire

// File: common/vram_bus_if.sv
/* register side vram port, select/acknowledge handshake
   requester holds sel, wr, addr and wdata until the one-cycle ack */
`default_nettype none
`timescale 1ns/100ps

interface vram_bus_if import vid_pkg::*; ();

logic   sel;        // request pending
logic   ack;        // one-cycle done strobe
logic   wr;         // 1 = write, 0 = read
addr_t  addr;       // word address
word_t  wdata;      // write word
word_t  rdata;      // read word, valid with ack

modport requester (
    output sel, wr, addr, wdata,
    input  ack, rdata
);

modport arbiter (
    input  sel, wr, addr, wdata,
    output ack, rdata
);

endinterface

`default_nettype wire

// File: logic/bus_regs.sv
/* cpu register file, bus inputs must be synchronous to clk
   cpu must wait for STATUS busy low before touching VRAM_ADDR or VRAM_DATA */
`default_nettype none
`timescale 1ns/100ps

module bus_regs import vid_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,     // register select, active low
    input  wire logic           bus_rd_nwr_i,   // 1 = read, 0 = write
    input  wire logic [3:0]     bus_reg_num_i,  // register number
    input  wire logic           bus_bytesel_i,  // 0 = even byte, 1 = odd byte
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    vram_bus_if.requester       vram,
    input  wire logic           hblank_i,
    input  wire logic           vblank_i,
    input  wire intr_t          intr_status_i,  // pending interrupts
    output intr_t               intr_mask_o,    // enabled interrupts
    output intr_t               intr_clear_o,   // clear strobe
    output intr_t               soft_trig_o     // software trigger strobe
);

typedef enum logic [1:0] {
    ST_IDLE,        // no vram traffic
    ST_WRITE,       // write word waiting for ack
    ST_GAP,         // sel low for one cycle between requests
    ST_READ         // prefetch read waiting for ack
} state_t;

state_t         state;
logic           cs_n_q;         // last chip select, for edge detect
logic           access;         // first cycle of a bus access
logic           is_wr;
logic           is_rd;
logic           start_wr;       // odd byte data write
logic           start_rd;       // address set or odd byte data read
logic           busy;
addr_t          vram_addr;      // auto-increment address
logic [7:0]     data_hi;        // even byte of the next write
word_t          wr_word;
word_t          rd_word;        // prefetched word
logic [7:0]     rd_byte;

assign access   = cs_n_q & ~bus_cs_n_i;
assign is_wr    = access & ~bus_rd_nwr_i;
assign is_rd    = access & bus_rd_nwr_i;
assign start_wr = is_wr && bus_reg_num_i == REG_VRAM_DATA && bus_bytesel_i;
assign start_rd = (is_wr && bus_reg_num_i == REG_VRAM_ADDR && bus_bytesel_i)
               || (is_rd && bus_reg_num_i == REG_VRAM_DATA && bus_bytesel_i);
assign busy     = (state != ST_IDLE);

assign vram.addr  = vram_addr;  // steady while busy
assign vram.wdata = wr_word;

// read mux, unmapped bytes read as zero
always_comb begin
    rd_byte = '0;
    case (bus_reg_num_i)
        REG_VRAM_DATA:  rd_byte = bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        REG_INT_CTRL:   if (bus_bytesel_i) rd_byte = {4'b0000, intr_status_i};
        REG_STATUS:     if (bus_bytesel_i) rd_byte = {busy, vblank_i, hblank_i, 5'b00000};
        default:        rd_byte = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state        <= ST_IDLE;
        cs_n_q       <= 1'b1;
        vram.sel     <= 1'b0;
        vram.wr      <= 1'b0;
        vram_addr    <= '0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
        soft_trig_o  <= '0;
    end else begin
        cs_n_q       <= bus_cs_n_i;
        intr_clear_o <= '0;     // strobes last one cycle
        soft_trig_o  <= '0;

        if (is_wr && bus_reg_num_i == REG_INT_CTRL) begin
            if (bus_bytesel_i) begin
                intr_clear_o <= bus_data_i[3:0];
            end else begin
                intr_mask_o  <= bus_data_i[3:0];
            end
        end
        if (is_wr && bus_reg_num_i == REG_SOFT_INTR && bus_bytesel_i) begin
            soft_trig_o <= {bus_data_i[3:1], 1'b0};    // bit 0 belongs to vblank
        end

        if (is_wr && bus_reg_num_i == REG_VRAM_ADDR) begin
            if (bus_bytesel_i) begin
                vram_addr[7:0]  <= bus_data_i;
            end else begin
                vram_addr[15:8] <= bus_data_i;
            end
        end else if (is_rd && bus_reg_num_i == REG_VRAM_DATA && bus_bytesel_i) begin
            vram_addr <= vram_addr + 1'b1;  // prefetch from the next word
        end else if (state == ST_WRITE && vram.ack) begin
            vram_addr <= vram_addr + 1'b1;
        end

        case (state)
            ST_IDLE: begin
                if (start_wr) begin
                    vram.sel <= 1'b1;
                    vram.wr  <= 1'b1;
                    state    <= ST_WRITE;
                end else if (start_rd) begin
                    vram.sel <= 1'b1;
                    vram.wr  <= 1'b0;
                    state    <= ST_READ;
                end
            end
            ST_WRITE: begin
                if (vram.ack) begin
                    vram.sel <= 1'b0;
                    state    <= ST_GAP;
                end
            end
            ST_GAP: begin
                vram.sel <= 1'b1;   // prefetch after write
                vram.wr  <= 1'b0;
                state    <= ST_READ;
            end
            ST_READ: begin
                if (vram.ack) begin
                    vram.sel <= 1'b0;
                    state    <= ST_IDLE;
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// payload registers
always_ff @(posedge clk) begin
    if (is_wr && bus_reg_num_i == REG_VRAM_DATA && !bus_bytesel_i) begin
        data_hi <= bus_data_i;
    end
    if (start_wr && state == ST_IDLE) begin
        wr_word <= {data_hi, bus_data_i};
    end
    if (state == ST_READ && vram.ack) begin
        rd_word <= vram.rdata;
    end
    if (is_rd) begin
        bus_data_o <= rd_byte;      // held until the next access
    end
end

endmodule

`default_nettype wire

// File: logic/vram_arb.sv
/* vram array, video fetch always wins over the register port
   only the low log2(VRAM_DEPTH) address bits index the array */
`default_nettype none
`timescale 1ns/100ps

module vram_arb import vid_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   fetch_sel_i,    // video fetch this cycle
    input  wire addr_t  fetch_addr_i,
    output word_t       fetch_data_o,   // one cycle after fetch_sel_i
    vram_bus_if.arbiter regs
);

localparam int AW = $clog2(VRAM_DEPTH);

word_t          mem [VRAM_DEPTH];
word_t          rdata_q;        // shared read register
logic           grant;
logic [AW-1:0]  rd_addr;

// no grant in the ack cycle, sel is still up then
assign grant   = regs.sel & ~fetch_sel_i & ~regs.ack;
assign rd_addr = fetch_sel_i ? fetch_addr_i[AW-1:0] : regs.addr[AW-1:0];

always_ff @(posedge clk) begin
    if (grant && regs.wr) begin
        mem[regs.addr[AW-1:0]] <= regs.wdata;
    end
    rdata_q <= mem[rd_addr];    // old data on a write
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        regs.ack <= 1'b0;
    end else begin
        regs.ack <= grant;      // rdata lands with ack
    end
end

assign fetch_data_o = rdata_q;
assign regs.rdata   = rdata_q;

endmodule

`default_nettype wire

// File: logic/intr_ctrl.sv
/* pending interrupt status with a one-cycle cpu interrupt pulse
   a trigger already pending gives no second pulse until cleared */
`default_nettype none
`timescale 1ns/100ps

module intr_ctrl import vid_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire intr_t  trig_i,     // raw triggers
    input  wire intr_t  mask_i,     // enabled sources
    input  wire intr_t  clear_i,    // cpu clear strobe
    output intr_t       status_o,   // pending bits
    output logic        bus_intr_o
);

always_ff @(posedge clk) begin
    if (reset_i) begin
        status_o   <= '0;
        bus_intr_o <= 1'b0;
    end else begin
        // new, enabled and not yet pending
        bus_intr_o <= |(trig_i & mask_i & ~status_o);
        status_o   <= (status_o | trig_i) & ~clear_i;  // masked triggers still latch
    end
end

endmodule

`default_nettype wire

// File: video/video_timing.sv
/* frame scan counters with active-low syncs and a linear fetch address
   every porch and sync width must be at least one */
`default_nettype none
`timescale 1ns/100ps

module video_timing import vid_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        de_o,           // visible pixel
    output logic        hblank_o,
    output logic        vblank_o,
    output logic        vblank_trig_o,  // first non-visible line
    output logic        fetch_sel_o,
    output addr_t       fetch_addr_o
);

localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
localparam int HW      = $clog2(H_TOTAL);
localparam int VW      = $clog2(V_TOTAL);

logic [HW-1:0]  h_count;
logic [VW-1:0]  v_count;
logic           h_vis;
logic           v_vis;
logic           h_end;
logic           h_sync_on;
logic           v_sync_on;

assign h_vis     = h_count < HW'(H_VISIBLE);
assign v_vis     = v_count < VW'(V_VISIBLE);
assign h_end     = h_count == HW'(H_TOTAL - 1);
assign h_sync_on = h_count >= HW'(H_VISIBLE + H_FRONT)
                && h_count <  HW'(H_VISIBLE + H_FRONT + H_SYNC);
assign v_sync_on = v_count >= VW'(V_VISIBLE + V_FRONT)
                && v_count <  VW'(V_VISIBLE + V_FRONT + V_SYNC);

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count       <= '0;
        v_count       <= '0;
        hsync_o       <= 1'b1;
        vsync_o       <= 1'b1;
        de_o          <= 1'b0;
        hblank_o      <= 1'b0;
        vblank_o      <= 1'b0;
        vblank_trig_o <= 1'b0;
        fetch_addr_o  <= '0;
    end else begin
        h_count <= h_end ? '0 : h_count + 1'b1;
        if (h_end) begin
            v_count <= (v_count == VW'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
        end

        // outputs lag the counters by one cycle
        de_o          <= h_vis & v_vis;
        hblank_o      <= ~h_vis;
        vblank_o      <= ~v_vis;
        hsync_o       <= ~h_sync_on;
        vsync_o       <= ~v_sync_on;
        vblank_trig_o <= (h_count == '0) && (v_count == VW'(V_VISIBLE));

        if (!v_vis) begin
            fetch_addr_o <= '0;     // restart for next frame
        end else if (de_o) begin
            fetch_addr_o <= (fetch_addr_o == addr_t'(VRAM_DEPTH - 1)) ? '0
                                                                      : fetch_addr_o + 1'b1;
        end
    end
end

assign fetch_sel_o = de_o;  // one word per visible pixel

endmodule

`default_nettype wire

// File: video/pixel_out.sv
/* two-stage output pipe, pixel_i arrives one cycle after de_i
   colour forced to zero outside display enable */
`default_nettype none
`timescale 1ns/100ps

module pixel_out import vid_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   de_i,
    input  wire logic   hsync_i,
    input  wire logic   vsync_i,
    input  wire word_t  pixel_i,    // fetched vram word
    output rgb_t        rgb_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        de_o
);

logic   de_1;       // lines up with pixel_i
logic   hsync_1;
logic   vsync_1;

always_ff @(posedge clk) begin
    if (reset_i) begin
        de_1    <= 1'b0;
        hsync_1 <= 1'b1;
        vsync_1 <= 1'b1;
        de_o    <= 1'b0;
        hsync_o <= 1'b1;
        vsync_o <= 1'b1;
        rgb_o   <= '0;
    end else begin
        de_1    <= de_i;
        hsync_1 <= hsync_i;
        vsync_1 <= vsync_i;
        de_o    <= de_1;
        hsync_o <= hsync_1;
        vsync_o <= vsync_1;
        rgb_o   <= de_1 ? pixel_i[11:0] : '0;  // top nibble ignored
    end
end

endmodule

`default_nettype wire

// File: logic/vid_top.sv
/* video controller top, cpu register bus in and 12-bit rgb out
   frames larger than VRAM_DEPTH pixels wrap the fetch address */
`default_nettype none
`timescale 1ns/100ps

module vid_top import vid_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire logic           clk,            // pixel clock
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,     // cpu interrupt pulse
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,        // active low
    output logic                vsync_o,        // active low
    output logic                dv_de_o
);

logic   hsync;
logic   vsync;
logic   de;
logic   hblank;
logic   vblank;
logic   vblank_trig;
logic   fetch_sel;
addr_t  fetch_addr;
word_t  fetch_data;
rgb_t   rgb;
intr_t  intr_mask;
intr_t  intr_clear;
intr_t  intr_status;
intr_t  soft_trig;
intr_t  intr_trig;

vram_bus_if regs_vram();

assign intr_trig = {soft_trig[3:1], vblank_trig};  // vblank owns bit 0

bus_regs bus_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .vram           (regs_vram.requester),
    .hblank_i       (hblank),
    .vblank_i       (vblank),
    .intr_status_i  (intr_status),
    .intr_mask_o    (intr_mask),
    .intr_clear_o   (intr_clear),
    .soft_trig_o    (soft_trig)
);

vram_arb vram_arb (
    .clk            (clk),
    .reset_i        (reset_i),
    .fetch_sel_i    (fetch_sel),
    .fetch_addr_i   (fetch_addr),
    .fetch_data_o   (fetch_data),
    .regs           (regs_vram.arbiter)
);

video_timing #(
    .H_VISIBLE  (H_VISIBLE),
    .H_FRONT    (H_FRONT),
    .H_SYNC     (H_SYNC),
    .H_BACK     (H_BACK),
    .V_VISIBLE  (V_VISIBLE),
    .V_FRONT    (V_FRONT),
    .V_SYNC     (V_SYNC),
    .V_BACK     (V_BACK)
) video_timing (
    .clk            (clk),
    .reset_i        (reset_i),
    .hsync_o        (hsync),
    .vsync_o        (vsync),
    .de_o           (de),
    .hblank_o       (hblank),
    .vblank_o       (vblank),
    .vblank_trig_o  (vblank_trig),
    .fetch_sel_o    (fetch_sel),
    .fetch_addr_o   (fetch_addr)
);

pixel_out pixel_out (
    .clk        (clk),
    .reset_i    (reset_i),
    .de_i       (de),
    .hsync_i    (hsync),
    .vsync_i    (vsync),
    .pixel_i    (fetch_data),
    .rgb_o      (rgb),
    .hsync_o    (hsync_o),
    .vsync_o    (vsync_o),
    .de_o       (dv_de_o)
);

intr_ctrl intr_ctrl (
    .clk        (clk),
    .reset_i    (reset_i),
    .trig_i     (intr_trig),
    .mask_i     (intr_mask),
    .clear_i    (intr_clear),
    .status_o   (intr_status),
    .bus_intr_o (bus_intr_o)
);

assign {red_o, green_o, blue_o} = rgb;

endmodule

`default_nettype wire

// File: sim/vid_checker.sv
/* watches the vid_top ports on the falling edge and keeps the check counts
   pixel colours are only compared for frames that start while pix_en is set */
`default_nettype none
`timescale 1ns/100ps

module vid_checker #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 3,
    parameter int H_BACK    = 3,
    parameter int V_VISIBLE = 4,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           dv_de_i,
    input  wire logic           hsync_i,
    input  wire logic           vsync_i,
    input  wire logic [11:0]    rgb_i,      // {red, green, blue}
    input  wire logic           bus_intr_i
);

localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

int             errors = 0;
int             checks = 0;
int             test_mark = 0;      // errors at the end of the last test
int             intr_count = 0;
int             frame_count = 0;    // vsync falling edges
int             pix_checked = 0;
logic           pix_en = 1'b0;
logic [11:0]    exp_rgb [64];       // low 12 bits of vram words 0 to 63
int             de_line, de_frame, h_cnt, v_cnt, pix_n, h_lines;
logic           h_seen, v_seen, armed, de_q, hs_q, vs_q;

task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
endtask

task automatic test_done(input string name);
    $display("test %-16s %s", name, (errors == test_mark) ? "ok" : "with errors");
    test_mark = errors;
endtask

task automatic report_counts();
    $display("checks %0d, errors %0d, frames %0d", checks, errors, frame_count);
endtask

always @(negedge clk) begin
    if (reset_i) begin
        {h_seen, v_seen, armed, de_q} = '0;
        {hs_q, vs_q} = 2'b11;
        {de_line, de_frame, h_cnt, v_cnt, pix_n, h_lines} = '0;
    end else begin
        h_cnt++;
        v_cnt++;
        if (bus_intr_i) intr_count++;
        if (dv_de_i) begin
            de_line++;
            de_frame++;
            if (armed && pix_n < 64) begin
                compare($sformatf("pixel %0d colour", pix_n), rgb_i, exp_rgb[pix_n]);
                pix_checked++;
            end
            pix_n++;
        end else begin
            compare("colour outside display enable", rgb_i, 0);
        end
        if (de_q && !dv_de_i) begin     // end of a visible line
            compare("pixels per line", de_line, H_VISIBLE);
            de_line = 0;
        end
        if (hs_q && !hsync_i) begin
            if (h_seen) compare("hsync period", h_cnt, H_TOTAL);
            h_seen = 1'b1;
            h_cnt  = 0;
            h_lines++;
        end
        if (vs_q && !vsync_i) begin     // frame boundary
            if (v_seen) begin
                compare("vsync period", v_cnt, H_TOTAL * V_TOTAL);
                compare("pixels per frame", de_frame, H_VISIBLE * V_VISIBLE);
                compare("lines per frame", h_lines, V_TOTAL);
            end
            v_seen   = 1'b1;
            v_cnt    = 0;
            de_frame = 0;
            pix_n    = 0;
            h_lines  = 0;
            armed    = pix_en;
            frame_count++;
        end
        de_q = dv_de_i;
        hs_q = hsync_i;
        vs_q = vsync_i;
    end
end

endmodule

`default_nettype wire

// File: sim/tb_vid_top.sv
/* testbench for vid_top on a 16x4 visible frame, inputs change on the falling edge
   every wait gives up after WAIT_LIMIT cycles */
`default_nettype none
`timescale 1ns/100ps

module tb_vid_top import vid_pkg::*; ();

localparam int WAIT_LIMIT = 2000;

logic clk, reset_i, bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i, bus_intr_o;
logic hsync_o, vsync_o, dv_de_o;
logic [3:0] bus_reg_num_i, red_o, green_o, blue_o;
logic [7:0] bus_data_i, bus_data_o, q;
logic [15:0] tbl_addr [8];      // write/read-back table
logic [15:0] tbl_data [8];
logic [15:0] w;
integer seed = 32'h6dde4fd3;
int mark, fr0;

vid_top #(.H_VISIBLE(16), .H_FRONT(2), .H_SYNC(3), .H_BACK(3),
          .V_VISIBLE(4), .V_FRONT(1), .V_SYNC(2), .V_BACK(1)) uut (.*);

vid_checker chk (.clk(clk), .reset_i(reset_i), .dv_de_i(dv_de_o), .hsync_i(hsync_o),
    .vsync_i(vsync_o), .rgb_i({red_o, green_o, blue_o}), .bus_intr_i(bus_intr_o));

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;     // 40 ns period
end

task automatic give_up(input string why);
    $display("timeout: %s", why);
    chk.report_counts();
    $display("STATUS: FAIL");
    $finish;
endtask

// one bus cycle, cs low for a single clock
task automatic bus_access(input logic rd, input logic [3:0] rn, input logic odd,
                          input logic [7:0] d, output logic [7:0] rdata);
    @(negedge clk);
    {bus_cs_n_i, bus_rd_nwr_i, bus_reg_num_i, bus_bytesel_i, bus_data_i} = {1'b0, rd, rn, odd, d};
    @(negedge clk);
    bus_cs_n_i = 1'b1;
    rdata = bus_data_o;         // registered at the access edge
endtask

task automatic write_reg(input logic [3:0] rn, input logic odd, input logic [7:0] d);
    logic [7:0] unused;
    bus_access(1'b0, rn, odd, d, unused);
endtask

task automatic wait_idle();
    int n;
    logic [7:0] st;
    n = 0;
    bus_access(1'b1, REG_STATUS, 1'b1, 8'h00, st);
    while (st[7]) begin
        n++;
        if (n > WAIT_LIMIT) give_up("STATUS busy never went low");
        bus_access(1'b1, REG_STATUS, 1'b1, 8'h00, st);
    end
endtask

task automatic set_addr(input logic [15:0] a);
    wait_idle();
    write_reg(REG_VRAM_ADDR, 1'b0, a[15:8]);
    write_reg(REG_VRAM_ADDR, 1'b1, a[7:0]);     // starts the prefetch
endtask

task automatic write_word(input logic [15:0] d);
    wait_idle();
    write_reg(REG_VRAM_DATA, 1'b0, d[15:8]);
    write_reg(REG_VRAM_DATA, 1'b1, d[7:0]);
endtask

task automatic read_word(output logic [15:0] d);
    wait_idle();
    bus_access(1'b1, REG_VRAM_DATA, 1'b0, 8'h00, d[15:8]);
    bus_access(1'b1, REG_VRAM_DATA, 1'b1, 8'h00, d[7:0]);
endtask

task automatic wait_intr(input int from);
    int n;
    n = 0;
    while (chk.intr_count == from) begin
        @(negedge clk);
        n++;
        if (n > WAIT_LIMIT) give_up("no interrupt pulse");
    end
endtask

task automatic wait_frames(input int cnt);
    int n, start;
    n = 0;
    start = chk.frame_count;
    while (chk.frame_count < start + cnt) begin
        @(negedge clk);
        n++;
        if (n > WAIT_LIMIT) give_up("frame did not end");
    end
endtask

initial begin
    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;       // bus idle
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = '0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = '0;
    for (int i = 0; i < 8; i++) begin
        tbl_addr[i] = (i < 4) ? 16'h0100 + 16'(i) : 16'h0800 + 16'(i);  // two runs
        tbl_data[i] = 16'($random(seed));
    end
    repeat (16) @(negedge clk);
    reset_i = 1'b0;

    // write the table, then read it back in auto-increment order
    for (int i = 0; i < 8; i++) begin
        if (i == 0 || tbl_addr[i] != tbl_addr[i-1] + 1) set_addr(tbl_addr[i]);
        write_word(tbl_data[i]);
    end
    for (int i = 0; i < 8; i++) begin
        if (i == 0 || tbl_addr[i] != tbl_addr[i-1] + 1) set_addr(tbl_addr[i]);
        read_word(w);
        chk.compare($sformatf("vram word %0d", i), w, tbl_data[i]);
    end
    chk.test_done("vram readback");

    wait_frames(3);             // checker measures lines and syncs meanwhile
    chk.test_done("frame timing");

    set_addr(16'h0000);
    for (int i = 0; i < 64; i++) begin
        w = 16'($random(seed));
        chk.exp_rgb[i] = w[11:0];
        write_word(w);
    end
    chk.pix_en = 1'b1;
    wait_frames(3);
    chk.compare("pixels compared", chk.pix_checked >= 128, 1);
    chk.test_done("pixel colour");

    write_reg(REG_INT_CTRL, 1'b1, 8'h0f);       // clear everything
    write_reg(REG_INT_CTRL, 1'b0, 8'h06);       // soft bits 1 and 2 only
    mark = chk.intr_count;
    write_reg(REG_SOFT_INTR, 1'b1, 8'h02);
    wait_intr(mark);
    repeat (4) @(negedge clk);
    chk.compare("soft interrupt pulses", chk.intr_count - mark, 1);
    mark = chk.intr_count;
    write_reg(REG_SOFT_INTR, 1'b1, 8'h02);      // still pending
    repeat (20) @(negedge clk);
    chk.compare("repeat soft interrupt pulses", chk.intr_count - mark, 0);
    write_reg(REG_SOFT_INTR, 1'b1, 8'h08);      // masked source
    repeat (20) @(negedge clk);
    chk.compare("masked interrupt pulses", chk.intr_count - mark, 0);
    bus_access(1'b1, REG_INT_CTRL, 1'b1, 8'h00, q);
    chk.compare("soft status", q & 8'h0e, 8'h0a);
    write_reg(REG_INT_CTRL, 1'b1, 8'h0a);
    bus_access(1'b1, REG_INT_CTRL, 1'b1, 8'h00, q);
    chk.compare("soft status after clear", q & 8'h0e, 8'h00);
    chk.test_done("soft interrupts");

    write_reg(REG_INT_CTRL, 1'b0, 8'h01);
    for (int k = 0; k < 2; k++) begin
        write_reg(REG_INT_CTRL, 1'b1, 8'h01);
        mark = chk.intr_count;
        wait_intr(mark);
        if (k == 1) chk.compare("frames between vblank pulses", chk.frame_count - fr0, 1);
        fr0 = chk.frame_count;
        bus_access(1'b1, REG_STATUS, 1'b1, 8'h00, q);
        chk.compare("STATUS vblank", q[6], 1);
        bus_access(1'b1, REG_INT_CTRL, 1'b1, 8'h00, q);
        chk.compare("vblank status bit", q[0], 1);
    end
    chk.test_done("vblank interrupt");

    set_addr(16'h0300);
    wait_idle();
    mark = 0;
    while (!dv_de_o) begin      // start the write inside a visible line
        @(negedge clk);
        mark++;
        if (mark > WAIT_LIMIT) give_up("display enable never rose");
    end
    bus_access(1'b1, REG_STATUS, 1'b1, 8'h00, q);
    chk.compare("STATUS blanking in a visible line", q[6:5], 2'b00);
    write_reg(REG_VRAM_DATA, 1'b0, 8'h5a);
    write_reg(REG_VRAM_DATA, 1'b1, 8'hc3);
    wait_idle();
    set_addr(16'h0300);
    read_word(w);
    chk.compare("write during active video", w, 16'h5ac3);
    chk.test_done("active access");

    chk.report_counts();
    if (chk.errors == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: files.f
common/vid_pkg.sv
common/vram_bus_if.sv
logic/bus_regs.sv
logic/vram_arb.sv
logic/intr_ctrl.sv
video/video_timing.sv
video/pixel_out.sv
logic/vid_top.sv
sim/vid_checker.sv
sim/tb_vid_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the vid_top testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_vid_top -o sim_vid \
    && ./obj_dir/sim_vid > sim.log 2>&1 \
    || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0
